/* hw/ntm_scalar_cfg.svh */
/*
 * Scalar modular multiplier configuration
 * Word size of operands and modulus, and the wait limit used by the testbench
 */

`ifndef NTM_SCALAR_CFG_SVH
`define NTM_SCALAR_CFG_SVH

// Operand and modulus width in bits
`define NTM_SCALAR_DATA_SIZE 16

// Upper bound in clock cycles on any testbench wait
// Worst reduction case is 65535 subtract steps plus the multiply
`define NTM_SCALAR_TIMEOUT 200000

`endif

/* hw/ntm_scalar_pkg.sv */
/*
 * Scalar modular multiplier types
 * Word type and the payload structs passed between the pipeline stages
 */

`default_nettype none

`include "ntm_scalar_cfg.svh"

package ntm_scalar_pkg;

  // Unsigned data word
  typedef logic [`NTM_SCALAR_DATA_SIZE-1:0] word_t;

  // Operand set handed from reduction stage to multiply core
  typedef struct packed {
    word_t modulus;
    word_t data_a;
    word_t data_b;
  } operand_set_t;

  // Core output register
  typedef struct packed {
    word_t result;
  } result_t;

endpackage

`default_nettype wire

/* hw/ntm_scalar_stage_if.sv */
/*
 * Pipeline stage link
 * Valid/ready handshake with a payload of parameterized type
 */

`default_nettype none

interface ntm_scalar_stage_if #(
  parameter type payload_t = logic
);

  // Handshake
  logic     valid;
  logic     ready;

  // Data carried on a transfer
  payload_t payload;

  // Producer side
  modport source (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

/* hw/ntm_scalar_mod.sv */
/*
 * Operand reduction stage
 * Reduces data_a and data_b mod modulus by repeated subtraction
 * Zero modulus passes both operands through unchanged
 */

`default_nettype none

module ntm_scalar_mod (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  output logic                  accept,
  input  ntm_scalar_pkg::word_t modulo,
  input  ntm_scalar_pkg::word_t data_a,
  input  ntm_scalar_pkg::word_t data_b,
  ntm_scalar_stage_if.source    out
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REDUCE,
    ST_HOLD
  } state_t;

  state_t                        state;

  // Working copy of modulus and operands
  ntm_scalar_pkg::operand_set_t  set_q;

  logic                          mod_zero;
  logic                          a_below;
  logic                          b_below;

  ////////////////////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////////////////////

  // No reduction at all for a zero modulus
  assign mod_zero = (set_q.modulus == '0);

  // Operand finished once below modulus
  assign a_below  = mod_zero || (set_q.data_a < set_q.modulus);
  assign b_below  = mod_zero || (set_q.data_b < set_q.modulus);

  // Only idle takes a new operation
  assign accept      = (state == ST_IDLE);

  // Reduced set offered until the core takes it
  assign out.valid   = (state == ST_HOLD);
  assign out.payload = set_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_REDUCE;
          end
        end
        ST_REDUCE: begin
          // Both operands reduced
          if (a_below && b_below) begin
            state <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          // Handoff to core
          if (out.ready) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      // Capture on the accepting edge
      set_q.modulus <= modulo;
      set_q.data_a  <= data_a;
      set_q.data_b  <= data_b;
    end else if (state == ST_REDUCE) begin
      // One subtraction per cycle, each operand on its own
      if (!a_below) begin
        set_q.data_a <= set_q.data_a - set_q.modulus;
      end
      if (!b_below) begin
        set_q.data_b <= set_q.data_b - set_q.modulus;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ntm_scalar_modmul_core.sv */
/*
 * Modular multiply core
 * Interleaved shift-and-add, data_a walked MSB first, one bit per cycle
 * Accumulator kept below the modulus after each step
 */

`default_nettype none

`include "ntm_scalar_cfg.svh"

module ntm_scalar_modmul_core (
  input  logic                  CLK,
  input  logic                  RST,
  ntm_scalar_stage_if.sink      in,
  output logic                  done,
  output ntm_scalar_pkg::word_t result
);

  ////////////////////////////////////////////////////////////////////////////
  // Parameters and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam int DW = `NTM_SCALAR_DATA_SIZE;
  localparam int CW = $clog2(DW + 1);

  // Control
  logic                    busy;
  logic [CW-1:0]           cnt;
  logic                    take;

  // Operands, data_a shifted left each step
  ntm_scalar_pkg::word_t   mod_q;
  ntm_scalar_pkg::word_t   a_sh;
  ntm_scalar_pkg::word_t   b_q;

  // Accumulator with one bit of headroom
  logic [DW:0]             acc;
  logic [DW:0]             acc_next;
  logic [DW:0]             dbl;
  logic [DW:0]             mod_ext;
  logic                    mod_zero;

  ntm_scalar_pkg::result_t res_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and outputs
  ////////////////////////////////////////////////////////////////////////////

  assign in.ready = !busy;
  assign take     = in.valid && !busy;
  assign result   = res_q.result;

  assign mod_ext  = {1'b0, mod_q};
  assign mod_zero = (mod_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // One multiply step
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Double, bit DW dropped so a zero modulus wraps
    dbl = {acc[DW-1:0], 1'b0};
    if (!mod_zero && dbl >= mod_ext) begin
      dbl = dbl - mod_ext;
    end
    acc_next = dbl;
    // Add data_b for a set bit, reduce again
    if (a_sh[DW-1]) begin
      acc_next = dbl + {1'b0, b_q};
      if (!mod_zero && acc_next >= mod_ext) begin
        acc_next = acc_next - mod_ext;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (take) begin
      mod_q <= in.payload.modulus;
      a_sh  <= in.payload.data_a;
      b_q   <= in.payload.data_b;
      acc   <= '0;
    end else if (busy && cnt != '0) begin
      acc   <= acc_next;
      a_sh  <= a_sh << 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control and result register
  ////////////////////////////////////////////////////////////////////////////

  // DW bit steps, then one cycle to load the result
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      cnt   <= '0;
      done  <= 1'b0;
      res_q <= '0;
    end else begin
      done <= 1'b0;
      if (take) begin
        busy <= 1'b1;
        cnt  <= CW'(DW);
      end else if (busy) begin
        if (cnt != '0) begin
          cnt <= cnt - 1'b1;
        end else begin
          // Last bit done
          busy         <= 1'b0;
          done         <= 1'b1;
          res_q.result <= acc[DW-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ntm_scalar_modmul.sv */
/*
 * Scalar modular multiplier
 * result = (data_a * data_b) mod modulo, two-stage pipeline
 */

`default_nettype none

`include "ntm_scalar_cfg.svh"

module ntm_scalar_modmul (
  input  logic                             CLK,
  input  logic                             RST,

  // Control
  input  logic                             start,
  output logic                             accept,
  output logic                             done,

  // Data
  input  logic [`NTM_SCALAR_DATA_SIZE-1:0] modulo,
  input  logic [`NTM_SCALAR_DATA_SIZE-1:0] data_a,
  input  logic [`NTM_SCALAR_DATA_SIZE-1:0] data_b,
  output logic [`NTM_SCALAR_DATA_SIZE-1:0] result
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage link
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_stage_if #(
    .payload_t (ntm_scalar_pkg::operand_set_t)
  ) mod_to_core ();

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  // Operand reduction
  ntm_scalar_mod u_mod (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .accept (accept),
    .modulo (modulo),
    .data_a (data_a),
    .data_b (data_b),
    .out    (mod_to_core.source)
  );

  // Modular multiply
  ntm_scalar_modmul_core u_core (
    .CLK    (CLK),
    .RST    (RST),
    .in     (mod_to_core.sink),
    .done   (done),
    .result (result)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock and reset generator
 * 100 ns clock, reset held high for the first 16 rising edges
 */

`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever begin
      #(HALF_PERIOD);
      CLK = ~CLK;
    end
  end

  // Reset from time zero, released on a rising edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

/* bench/tb_ntm_scalar_modmul.sv */
/*
 * Testbench for the scalar modular multiplier
 * LFSR stimulus with results checked in order against a wide-arithmetic model
 */

`default_nettype none

`include "ntm_scalar_cfg.svh"

module tb_ntm_scalar_modmul;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW    = `NTM_SCALAR_DATA_SIZE;
  localparam int LIMIT = `NTM_SCALAR_TIMEOUT;

  ////////////////////////////////////////////////////////////////////////////
  // Signals and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  logic                  CLK;
  logic                  RST;
  logic                  start;
  logic                  accept;
  logic                  done;
  ntm_scalar_pkg::word_t modulo;
  ntm_scalar_pkg::word_t data_a;
  ntm_scalar_pkg::word_t data_b;
  ntm_scalar_pkg::word_t result;

  // Random source
  logic [31:0]           lfsr_state = 32'hf784ea36;

  // Expected results in accept order and the test of each
  ntm_scalar_pkg::word_t exp_q[$];
  string                 name_q[$];

  int                    max_in_flight  = 0;
  logic                  done_last      = 1'b0;
  ntm_scalar_pkg::word_t last_result    = '0;

  tb_clock_gen clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_scalar_modmul UUT (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .accept (accept),
    .modulo (modulo),
    .data_a (data_a),
    .data_b (data_b),
    .done   (done),
    .result (result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Nonzero 8-bit modulus
  function automatic ntm_scalar_pkg::word_t random_modulus();
    logic [31:0] m;
    m = random_bits(8);
    while (m == 0) begin
      m = random_bits(8);
    end
    return DW'(m);
  endfunction

  // Full product reduced mod m or truncated for m of zero
  function automatic ntm_scalar_pkg::word_t model_modmul(
    input ntm_scalar_pkg::word_t a,
    input ntm_scalar_pkg::word_t b,
    input ntm_scalar_pkg::word_t m
  );
    logic [2*DW-1:0] product;
    product = (2*DW)'(a) * (2*DW)'(b);
    if (m == '0) begin
      return product[DW-1:0];
    end
    return DW'(product % (2*DW)'(m));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    if (expected !== actual) begin
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
      fail_run("value mismatch");
    end
  endtask

  // Hold start until an edge with accept high takes the operation
  task automatic issue_op(
    input string                 name,
    input ntm_scalar_pkg::word_t op_mod,
    input ntm_scalar_pkg::word_t op_a,
    input ntm_scalar_pkg::word_t op_b
  );
    int cycles;
    @(posedge CLK);
    start  <= 1'b1;
    modulo <= op_mod;
    data_a <= op_a;
    data_b <= op_b;
    cycles = 0;
    @(negedge CLK);
    while (!accept) begin
      if (cycles == LIMIT) begin
        fail_run("timeout: accept never went high for a new operation");
      end
      cycles++;
      @(negedge CLK);
    end
    // Accepting edge
    @(posedge CLK);
    start <= 1'b0;
    exp_q.push_back(model_modmul(op_a, op_b, op_mod));
    name_q.push_back(name);
    if (exp_q.size() > max_in_flight) begin
      max_in_flight = exp_q.size();
    end
  endtask

  // All results out and reduction stage idle
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (exp_q.size() != 0 || !accept) begin
      if (cycles == LIMIT) begin
        fail_run("timeout: pending results never all arrived");
      end
      cycles++;
      @(negedge CLK);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  // Sampled mid-cycle away from the driving edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (done) begin
        if (done_last) begin
          fail_run("done stayed high for more than one cycle");
        end else if (exp_q.size() == 0) begin
          fail_run("done pulsed with no operation pending");
        end else begin
          check_value(name_q.pop_front(), 32'(exp_q.pop_front()), 32'(result));
        end
      end else if (result !== last_result) begin
        fail_run("result changed outside a done cycle");
      end
      done_last   = done;
      last_result = result;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                    cycles;
    int                    lat;
    ntm_scalar_pkg::word_t m;
    ntm_scalar_pkg::word_t a;
    ntm_scalar_pkg::word_t b;

    start  = 1'b0;
    modulo = '0;
    data_a = '0;
    data_b = '0;

    // Reset state
    cycles = 0;
    @(negedge CLK);
    while (RST) begin
      check_value("reset_done", 0, 32'(done));
      check_value("reset_accept", 1, 32'(accept));
      if (cycles == LIMIT) begin
        fail_run("timeout: reset was never released");
      end
      cycles++;
      @(negedge CLK);
    end
    check_value("after_reset_done", 0, 32'(done));
    check_value("after_reset_accept", 1, 32'(accept));
    check_value("after_reset_result", 0, 32'(result));

    // Random products with operands often above the modulus
    repeat (200) begin
      m = random_modulus();
      a = DW'(random_bits(DW));
      b = DW'(random_bits(DW));
      issue_op("random_product", m, a, b);
    end
    wait_idle();

    // Operand edge cases
    m = random_modulus();
    issue_op("operand_equals_modulus", m, m, DW'(random_bits(DW)));
    issue_op("operand_equals_modulus", m, DW'(random_bits(DW)), m);
    issue_op("operands_below_modulus", DW'(200), DW'(17), DW'(150));
    issue_op("operands_below_modulus", '1, DW'(-2), DW'(-2));
    issue_op("data_a_zero", random_modulus(), '0, DW'(random_bits(DW)));
    repeat (4) begin
      a = DW'(random_bits(DW));
      b = DW'(random_bits(DW));
      issue_op("modulus_one", DW'(1), a, b);
    end
    wait_idle();

    // Zero modulus wraps the product at DW bits
    repeat (20) begin
      a = DW'(random_bits(DW));
      b = DW'(random_bits(DW));
      issue_op("zero_modulus", '0, a, b);
    end
    wait_idle();

    // Short reductions so the next op waits behind a busy core
    max_in_flight = 0;
    repeat (40) begin
      m = DW'(random_bits(7)) | DW'(128);
      a = DW'(random_bits(10));
      b = DW'(random_bits(10));
      issue_op("back_to_back", m, a, b);
    end
    wait_idle();
    check_value("back_to_back_overlap", 1, 32'(max_in_flight >= 2));

    // Long reduction with a stray start pulse while accept is low
    issue_op("core_latency", DW'(3), DW'(300), DW'(77));
    @(negedge CLK);
    check_value("accept_low_while_reducing", 0, 32'(accept));
    @(posedge CLK);
    start  <= 1'b1;
    modulo <= DW'(random_bits(8));
    data_a <= DW'(random_bits(DW));
    data_b <= DW'(random_bits(DW));
    @(posedge CLK);
    start <= 1'b0;

    // accept rises on the handoff edge
    cycles = 0;
    @(negedge CLK);
    while (!accept) begin
      if (cycles == LIMIT) begin
        fail_run("timeout: operation never handed off to the core");
      end
      cycles++;
      @(negedge CLK);
    end
    lat = 1;
    @(negedge CLK);
    while (!done) begin
      if (lat == LIMIT) begin
        fail_run("timeout: done never came after the handoff");
      end
      lat++;
      @(negedge CLK);
    end
    check_value("core_latency", DW + 1, lat);

    // Monitor flags any late extra done in this window
    wait_idle();
    repeat (4 * DW) @(negedge CLK);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* ntm_scalar_modmul.f */
+incdir+hw
hw/ntm_scalar_pkg.sv
hw/ntm_scalar_stage_if.sv
hw/ntm_scalar_mod.sv
hw/ntm_scalar_modmul_core.sv
hw/ntm_scalar_modmul.sv
bench/tb_clock_gen.sv
bench/tb_ntm_scalar_modmul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ntm_scalar_modmul testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_ntm_scalar_modmul
OBJ_DIR=obj_dir

# Warnings are still reported but do not stop the build
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f ntm_scalar_modmul.f --top-module "$TOP" --Mdir "$OBJ_DIR" -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

# A $fatal in the testbench gives a nonzero exit status
"./$OBJ_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished"
exit 0
